// File: hw/wb_pkg.sv
// host bus widths, slave slot numbers and slave address decode
`default_nettype none

package wb_pkg;

   localparam int WB_DW       = 16;  // host data width
   localparam int WB_AW       = 11;  // halfword address width
   localparam int WB_DECODE_W = 4;   // top address bits used to pick a slave

   typedef enum logic [WB_DECODE_W-1:0] {
      SLV_MISC     = 4'h0,
      SLV_READBACK = 4'h7,
      SLV_SETTINGS = 4'h8   // spans slots 8 to 15
   } slave_e;

   // cleared mask bits are don't care
   localparam logic [WB_DECODE_W-1:0] MASK_MISC     = 4'hf;
   localparam logic [WB_DECODE_W-1:0] MASK_READBACK = 4'hf;
   localparam logic [WB_DECODE_W-1:0] MASK_SETTINGS = 4'h8;

   function automatic logic slave_hit(input logic [WB_DECODE_W-1:0] top,
                                      input slave_e                  slot,
                                      input logic [WB_DECODE_W-1:0] mask);
      return ((top ^ slot) & mask) == '0;
   endfunction

endpackage

`default_nettype wire

// File: hw/regmap_pkg.sv
// settings addresses, readback word map and misc register map of the control plane
`default_nettype none

package regmap_pkg;

   localparam int SR_AW = 8;   // setting address width

   // one 32-bit setting write
   typedef struct packed {
      logic             strobe;
      logic [SR_AW-1:0] addr;
      logic [31:0]      data;
   } set_bus_t;

   localparam logic [SR_AW-1:0] SR_TIME64     = 8'd42;  // +0 secs, +1 ticks, +2 load cmd
   localparam logic [SR_AW-1:0] SR_REG_TEST32 = 8'd60;

   // misc halfword addresses on adr[6:0]
   typedef enum logic [6:0] {
      MISC_CGEN_CTRL = 7'd4,
      MISC_CGEN_ST   = 7'd6,
      MISC_TEST      = 7'd8
   } misc_reg_e;

   localparam logic [15:0] MISC_DEFAULT = 16'hbeef;

   typedef enum logic [4:0] {
      RB_TIME_HI = 5'd0,
      RB_TIME_LO = 5'd1,
      RB_PPS_HI  = 5'd2,
      RB_PPS_LO  = 5'd3,
      RB_TEST32  = 5'd4,
      RB_COMPAT  = 5'd6
   } rb_word_e;

   localparam logic [31:0] COMPAT_NUM = {16'd9, 16'd0};  // major, minor

endpackage

`default_nettype wire

// File: hw/wb_slave_if.sv
// one decoded slave port of the host control bus
`timescale 1ns/1ps
`default_nettype none

interface wb_slave_if;
   import wb_pkg::*;

   logic [WB_AW-1:0] adr;
   logic [WB_DW-1:0] dat_w;
   logic             we;
   logic             stb;    // already qualified by cyc and decode
   logic [WB_DW-1:0] dat_r;
   logic             ack;

   modport master (output adr, dat_w, we, stb, input dat_r, ack);
   modport slave  (input adr, dat_w, we, stb, output dat_r, ack);

endinterface

`default_nettype wire

// File: hw/wb_intercon.sv
// single master interconnect, decodes host accesses onto three slave ports
`timescale 1ns/1ps
`default_nettype none

module wb_intercon
   (input  wire                        wb_clk,
    input  wire                        wb_rst,
    input  wire                        cyc_i,
    input  wire                        stb_i,
    input  wire                        we_i,
    input  wire [wb_pkg::WB_AW-1:0]    adr_i,
    input  wire [wb_pkg::WB_DW-1:0]    dat_i,
    output logic [wb_pkg::WB_DW-1:0]   dat_o,
    output logic                       ack_o,
    wb_slave_if.master                 misc_o,
    wb_slave_if.master                 settings_o,
    wb_slave_if.master                 readback_o);

   import wb_pkg::*;

   logic [WB_DECODE_W-1:0] top;
   logic                   access;
   logic                   hit_misc;
   logic                   hit_settings;
   logic                   hit_readback;

   assign top          = adr_i[WB_AW-1 -: WB_DECODE_W];
   assign access       = cyc_i & stb_i;
   assign hit_misc     = slave_hit(top, SLV_MISC, MASK_MISC);
   assign hit_readback = slave_hit(top, SLV_READBACK, MASK_READBACK);
   assign hit_settings = slave_hit(top, SLV_SETTINGS, MASK_SETTINGS);

   // address, data and direction fan out to everybody
   assign misc_o.adr       = adr_i;
   assign misc_o.dat_w     = dat_i;
   assign misc_o.we        = we_i;
   assign misc_o.stb       = access & hit_misc;
   assign settings_o.adr   = adr_i;
   assign settings_o.dat_w = dat_i;
   assign settings_o.we    = we_i;
   assign settings_o.stb   = access & hit_settings;
   assign readback_o.adr   = adr_i;
   assign readback_o.dat_w = dat_i;
   assign readback_o.we    = we_i;
   assign readback_o.stb   = access & hit_readback;

   // return path, unmapped slots stay silent
   always_comb
   begin
      dat_o = '0;
      ack_o = 1'b0;
      if (hit_misc)
      begin
         dat_o = misc_o.dat_r;
         ack_o = misc_o.ack;
      end
      else if (hit_readback)
      begin
         dat_o = readback_o.dat_r;
         ack_o = readback_o.ack;
      end
      else if (hit_settings)
      begin
         dat_o = settings_o.dat_r;
         ack_o = settings_o.ack;
      end
   end

endmodule

`default_nettype wire

// File: hw/misc_regs.sv
// misc slave with clock generator control, scratch register and status readback
`timescale 1ns/1ps
`default_nettype none

module misc_regs
   (input  wire  wb_clk,
    input  wire  wb_rst,
    wb_slave_if.slave bus_i,
    input  wire  cgen_st_status_i,
    input  wire  cgen_st_ld_i,
    input  wire  cgen_st_refmon_i,
    output logic cgen_sync_b_o,
    output logic cgen_ref_sel_o);

   import wb_pkg::*;
   import regmap_pkg::*;

   logic [1:0]       cgen_ctrl;   // {sync_b, ref_sel}
   logic [WB_DW-1:0] scratch;
   logic             wr;

   assign wr = bus_i.stb & bus_i.we;

   always_ff @(posedge wb_clk)
   begin
      if (wb_rst)
         cgen_ctrl <= 2'b11;
      else if (wr && bus_i.adr[6:0] == MISC_CGEN_CTRL)
         cgen_ctrl <= bus_i.dat_w[1:0];
   end

   always_ff @(posedge wb_clk)
   begin
      if (wr && bus_i.adr[6:0] == MISC_TEST)
         scratch <= bus_i.dat_w;
   end

   assign {cgen_sync_b_o, cgen_ref_sel_o} = cgen_ctrl;

   always_comb
   begin
      case (bus_i.adr[6:0])
         MISC_CGEN_CTRL: bus_i.dat_r = {{(WB_DW-2){1'b0}}, cgen_ctrl};
         MISC_CGEN_ST:   bus_i.dat_r = {{(WB_DW-3){1'b0}}, cgen_st_status_i,
                                        cgen_st_ld_i, cgen_st_refmon_i};
         MISC_TEST:      bus_i.dat_r = scratch;
         default:        bus_i.dat_r = MISC_DEFAULT;
      endcase
   end

   assign bus_i.ack = bus_i.stb;   // zero wait state

endmodule

`default_nettype wire

// File: hw/settings_bus_16le.sv
// joins little-endian halfword writes into 32-bit settings bus strobes
`timescale 1ns/1ps
`default_nettype none

module settings_bus_16le
   (input  wire  wb_clk,
    input  wire  wb_rst,
    wb_slave_if.slave bus_i,
    output regmap_pkg::set_bus_t set_o);

   import wb_pkg::*;
   import regmap_pkg::*;

   typedef enum logic {
      SB_IDLE,
      SB_HAVE_LOW
   } sb_state_e;

   sb_state_e        state;
   logic [WB_DW-1:0] data_lo;
   logic             set_stb;
   logic [SR_AW-1:0] set_addr;
   logic [31:0]      set_data;
   logic             wr_done;    // last cycle of an acked write
   logic             wr_high;

   assign wr_done = bus_i.stb & bus_i.ack & bus_i.we;
   assign wr_high = bus_i.adr[1];

   //////////////////////////////
   // handshake and FSM
   always_ff @(posedge wb_clk)
   begin
      if (wb_rst)
      begin
         bus_i.ack <= 1'b0;
         set_stb   <= 1'b0;
         state     <= SB_IDLE;
      end
      else
      begin
         bus_i.ack <= bus_i.stb & ~bus_i.ack;
         set_stb   <= wr_done & wr_high;
         if (wr_done)
            state <= wr_high ? SB_IDLE : SB_HAVE_LOW;
      end
   end

   //////////////////////////////
   // payload
   always_ff @(posedge wb_clk)
   begin
      if (wr_done && !wr_high)
         data_lo <= bus_i.dat_w;
      if (wr_done && wr_high)
      begin
         set_addr <= bus_i.adr[9:2];
         // a lone high write carries a zero low half
         set_data <= {bus_i.dat_w, (state == SB_HAVE_LOW) ? data_lo : {WB_DW{1'b0}}};
      end
   end

   assign bus_i.dat_r = '0;   // write only

   assign set_o.strobe = set_stb;
   assign set_o.addr   = set_addr;
   assign set_o.data   = set_data;

endmodule

`default_nettype wire

// File: hw/vita_timer.sv
// 64-bit vita time counter in seconds and ticks with pps latch and settable load
`timescale 1ns/1ps
`default_nettype none

module vita_timer
  #(parameter int unsigned TICKS_PER_SEC = 64_000_000)
   (input  wire                  wb_clk,
    input  wire                  wb_rst,
    input  wire                  pps_i,
    input  regmap_pkg::set_bus_t set_i,
    output logic [63:0]          time_o,
    output logic [63:0]          time_pps_o);

   import regmap_pkg::*;

   localparam logic [31:0] TICK_LAST = 32'(TICKS_PER_SEC - 1);

   logic [31:0] secs;
   logic [31:0] ticks;
   logic [31:0] pend_secs;
   logic [31:0] pend_ticks;
   logic        armed;       // load waits for next pps
   logic [2:0]  pps_sync;    // two sync stages plus edge delay
   logic        pps_edge;
   logic        load_cmd;
   logic        load_now;

   assign load_cmd = set_i.strobe && (set_i.addr == SR_TIME64 + 8'd2);
   assign load_now = load_cmd && set_i.data[0];
   assign pps_edge = pps_sync[1] & ~pps_sync[2];

   //////////////////////////////
   // pending time and pps sync
   always_ff @(posedge wb_clk)
   begin
      if (set_i.strobe && set_i.addr == SR_TIME64)
         pend_secs <= set_i.data;
      if (set_i.strobe && set_i.addr == SR_TIME64 + 8'd1)
         pend_ticks <= set_i.data;
   end

   always_ff @(posedge wb_clk)
   begin
      if (wb_rst)
         pps_sync <= '0;
      else
         pps_sync <= {pps_sync[1:0], pps_i};
   end

   //////////////////////////////
   // time counter
   always_ff @(posedge wb_clk)
   begin
      if (wb_rst)
      begin
         secs  <= '0;
         ticks <= '0;
         armed <= 1'b0;
      end
      else
      begin
         if (load_now || (pps_edge && armed))
         begin
            secs  <= pend_secs;
            ticks <= pend_ticks;
         end
         else if (ticks == TICK_LAST)
         begin
            ticks <= '0;
            secs  <= secs + 32'd1;
         end
         else
            ticks <= ticks + 32'd1;

         if (load_cmd)
            armed <= ~set_i.data[0];
         else if (pps_edge)
            armed <= 1'b0;
      end
   end

   always_ff @(posedge wb_clk)
   begin
      if (pps_edge)
         time_pps_o <= {secs, ticks};   // time seen at the edge
   end

   assign time_o = {secs, ticks};

endmodule

`default_nettype wire

// File: hw/readback_mux_16le.sv
// 32-bit readback words with test register, read as 16-bit halves
`timescale 1ns/1ps
`default_nettype none

module readback_mux_16le
   (input  wire                  wb_clk,
    input  wire                  wb_rst,
    wb_slave_if.slave            bus_i,
    input  regmap_pkg::set_bus_t set_i,
    input  wire [63:0]           time_i,
    input  wire [63:0]           time_pps_i);

   import wb_pkg::*;
   import regmap_pkg::*;

   logic [31:0]      test32;
   logic [31:0]      word;
   logic [WB_DW-1:0] half;

   always_ff @(posedge wb_clk)
   begin
      if (set_i.strobe && set_i.addr == SR_REG_TEST32)
         test32 <= set_i.data;
   end

   // word select on adr[6:2]
   always_comb
   begin
      case (bus_i.adr[6:2])
         RB_TIME_HI: word = time_i[63:32];      // seconds
         RB_TIME_LO: word = time_i[31:0];       // ticks
         RB_PPS_HI:  word = time_pps_i[63:32];
         RB_PPS_LO:  word = time_pps_i[31:0];
         RB_TEST32:  word = test32;
         RB_COMPAT:  word = COMPAT_NUM;
         default:    word = '0;
      endcase
   end

   assign half = bus_i.adr[1] ? word[31:16] : word[15:0];   // low half at even address

   always_ff @(posedge wb_clk)
   begin
      if (wb_rst)
         bus_i.ack <= 1'b0;
      else
         bus_i.ack <= bus_i.stb & ~bus_i.ack;
   end

   always_ff @(posedge wb_clk)
   begin
      if (bus_i.stb)
         bus_i.dat_r <= half;
   end

endmodule

`default_nettype wire

// File: hw/ctrl_core.sv
// control plane top with host bus, misc registers, settings bus, vita time and readback
`timescale 1ns/1ps
`default_nettype none

module ctrl_core
  #(parameter int unsigned TICKS_PER_SEC = 64_000_000)
   (input  wire                       wb_clk,
    input  wire                       wb_rst,
    input  wire                       wb_cyc_i,
    input  wire                       wb_stb_i,
    input  wire                       wb_we_i,
    input  wire [wb_pkg::WB_AW-1:0]   wb_adr_i,
    input  wire [wb_pkg::WB_DW-1:0]   wb_dat_i,
    output logic [wb_pkg::WB_DW-1:0]  wb_dat_o,
    output logic                      wb_ack_o,
    input  wire                       pps_i,
    input  wire                       cgen_st_status_i,
    input  wire                       cgen_st_ld_i,
    input  wire                       cgen_st_refmon_i,
    output logic                      cgen_sync_b_o,
    output logic                      cgen_ref_sel_o);

   import regmap_pkg::*;

   wb_slave_if misc_bus ();
   wb_slave_if settings_bus ();
   wb_slave_if readback_bus ();

   set_bus_t    set_bus;
   logic [63:0] vita_time;
   logic [63:0] vita_time_pps;

   //////////////////////////////
   // host bus decode
   wb_intercon intercon_i
     (.wb_clk(wb_clk), .wb_rst(wb_rst),
      .cyc_i(wb_cyc_i), .stb_i(wb_stb_i), .we_i(wb_we_i),
      .adr_i(wb_adr_i), .dat_i(wb_dat_i),
      .dat_o(wb_dat_o), .ack_o(wb_ack_o),
      .misc_o(misc_bus.master),
      .settings_o(settings_bus.master),
      .readback_o(readback_bus.master));

   misc_regs misc_i    // slot 0
     (.wb_clk(wb_clk), .wb_rst(wb_rst), .bus_i(misc_bus.slave),
      .cgen_st_status_i(cgen_st_status_i), .cgen_st_ld_i(cgen_st_ld_i),
      .cgen_st_refmon_i(cgen_st_refmon_i),
      .cgen_sync_b_o(cgen_sync_b_o), .cgen_ref_sel_o(cgen_ref_sel_o));

   settings_bus_16le settings_i    // slots 8 to 15
     (.wb_clk(wb_clk), .wb_rst(wb_rst), .bus_i(settings_bus.slave), .set_o(set_bus));

   //////////////////////////////
   // settings consumers
   vita_timer #(.TICKS_PER_SEC(TICKS_PER_SEC)) timer_i
     (.wb_clk(wb_clk), .wb_rst(wb_rst), .pps_i(pps_i), .set_i(set_bus),
      .time_o(vita_time), .time_pps_o(vita_time_pps));

   readback_mux_16le readback_i    // slot 7
     (.wb_clk(wb_clk), .wb_rst(wb_rst), .bus_i(readback_bus.slave), .set_i(set_bus),
      .time_i(vita_time), .time_pps_i(vita_time_pps));

endmodule

`default_nettype wire

// File: test/ctrl_core_props.sv
// concurrent checks on host handshake, settings strobe and clock generator reset state
`timescale 1ns/1ps
`default_nettype none

module ctrl_core_props
   (input wire                  wb_clk,
    input wire                  wb_rst,
    input wire                  cyc_i,
    input wire                  stb_i,
    input wire                  ack_i,
    input regmap_pkg::set_bus_t set_i,
    input wire                  sync_b_i,
    input wire                  ref_sel_i);

   //////////////////////////////
   // host bus
   ack_in_access: assert property
      (@(posedge wb_clk) disable iff (wb_rst)
       $rose(ack_i) |-> (cyc_i && stb_i))
      else $error("host ack rose outside an active access");

   ack_one_cycle: assert property
      (@(posedge wb_clk) disable iff (wb_rst)
       ack_i |=> !ack_i)   // master drops stb after ack
      else $error("host ack held for two cycles");

   //////////////////////////////
   // settings bus
   set_one_cycle: assert property
      (@(posedge wb_clk) disable iff (wb_rst)
       set_i.strobe |=> !set_i.strobe)
      else $error("settings strobe held for two cycles");

   // both outputs come out of reset high
   cgen_after_reset: assert property
      (@(posedge wb_clk)
       wb_rst |=> (sync_b_i && ref_sel_i))
      else $error("cgen outputs not high after reset");

endmodule

bind ctrl_core ctrl_core_props props_i
  (.wb_clk(wb_clk), .wb_rst(wb_rst),
   .cyc_i(wb_cyc_i), .stb_i(wb_stb_i), .ack_i(wb_ack_o),
   .set_i(set_bus),
   .sync_b_i(cgen_sync_b_o), .ref_sel_i(cgen_ref_sel_o));

`default_nettype wire

// File: test/tb_ctrl_core.sv
// testbench for the control plane, drives the host bus, pps and clock generator status
`timescale 1ns/1ps
`default_nettype none

module tb_ctrl_core;
   import wb_pkg::*;
   import regmap_pkg::*;

   localparam logic [31:0] TICKS      = 32'd1000;
   localparam int          MAX_CYCLES = 20_000;  // tests take a few hundred cycles
   localparam int          ACK_LIMIT  = 16;

   logic             wb_clk;
   logic             wb_rst;
   logic             wb_cyc_i;
   logic             wb_stb_i;
   logic             wb_we_i;
   logic [WB_AW-1:0] wb_adr_i;
   logic [WB_DW-1:0] wb_dat_i;
   logic [WB_DW-1:0] wb_dat_o;
   logic             wb_ack_o;
   logic             pps_i;
   logic             st_status;
   logic             st_ld;
   logic             st_refmon;
   logic             cgen_sync_b;
   logic             cgen_ref_sel;

   int          errors = 0;
   int          checks = 0;
   int          tests = 0;
   int          mark;
   int          cycles;
   integer      seed = 32'hdfff_65b7;
   logic [31:0] rnd;
   logic [15:0] rd;
   logic [31:0] secs_set;
   logic [31:0] secs_pps;
   logic [63:0] t_now;
   logic [63:0] t_after;
   logic [63:0] t_pps;

   ctrl_core #(.TICKS_PER_SEC(TICKS)) dut_i
     (.wb_clk(wb_clk), .wb_rst(wb_rst), .wb_cyc_i(wb_cyc_i), .wb_stb_i(wb_stb_i),
      .wb_we_i(wb_we_i), .wb_adr_i(wb_adr_i), .wb_dat_i(wb_dat_i),
      .wb_dat_o(wb_dat_o), .wb_ack_o(wb_ack_o), .pps_i(pps_i),
      .cgen_st_status_i(st_status), .cgen_st_ld_i(st_ld), .cgen_st_refmon_i(st_refmon),
      .cgen_sync_b_o(cgen_sync_b), .cgen_ref_sel_o(cgen_ref_sel));

   initial
   begin
      wb_clk = 1'b0;
      forever #5 wb_clk = ~wb_clk;
   end

   //////////////////////////////
   // address map, slot in the top four bits
   function automatic logic [WB_AW-1:0] misc_adr(input logic [6:0] r);
      return {4'd0, r};
   endfunction

   function automatic logic [WB_AW-1:0] rb_adr(input logic [4:0] word, input logic hi);
      return {4'd7, word, hi, 1'b0};   // high half at the odd halfword
   endfunction

   function automatic logic [WB_AW-1:0] sr_adr(input logic [7:0] sr, input logic hi);
      return {1'b1, sr, hi, 1'b0};
   endfunction

   //////////////////////////////
   // bus and check tasks
   task automatic host_access(input logic we, input logic [WB_AW-1:0] adr,
                              input logic [15:0] wdat, output logic [15:0] rdat);
      int waited;
      waited = 0;
      @(posedge wb_clk);
      #1;
      wb_cyc_i = 1'b1;
      wb_stb_i = 1'b1;
      wb_we_i  = we;
      wb_adr_i = adr;
      wb_dat_i = wdat;
      @(negedge wb_clk);
      while (!wb_ack_o && waited < ACK_LIMIT)
      begin
         @(negedge wb_clk);
         waited++;
      end
      rdat = wb_dat_o;
      if (!wb_ack_o)
      begin
         $display("bus access to address %h got no ack by %0t ns", adr, $time);
         errors++;
      end
      @(posedge wb_clk);
      #1;
      wb_cyc_i = 1'b0;   // stb drops in the cycle after ack
      wb_stb_i = 1'b0;
      wb_we_i  = 1'b0;
   endtask

   task automatic put_setting(input logic [7:0] sr, input logic [31:0] val);
      logic [15:0] dummy;
      host_access(1'b1, sr_adr(sr, 1'b0), val[15:0], dummy);   // low half first
      host_access(1'b1, sr_adr(sr, 1'b1), val[31:16], dummy);
   endtask

   // reads two readback words as {word, word + 1}
   task automatic read_time(input logic [WB_AW-1:0] base, output logic [63:0] t);
      logic [15:0] h0;
      logic [15:0] h1;
      logic [15:0] h2;
      logic [15:0] h3;
      host_access(1'b0, base, 16'h0, h0);
      host_access(1'b0, base + 11'd2, 16'h0, h1);
      host_access(1'b0, base + 11'd4, 16'h0, h2);
      host_access(1'b0, base + 11'd6, 16'h0, h3);
      t = {h1, h0, h3, h2};
   endtask

   task automatic expect_eq(input string what, input logic [15:0] got, input logic [15:0] exp);
      checks++;
      assert (got === exp)
      else
      begin
         $display("CHECK FAILED at %0t ns: %s got %h expected %h", $time, what, got, exp);
         errors++;
      end
   endtask

   task automatic expect_true(input string what, input logic ok);
      checks++;
      assert (ok === 1'b1)
      else
      begin
         $display("CHECK FAILED at %0t ns: %s", $time, what);
         errors++;
      end
   endtask

   task automatic pulse_pps();
      @(posedge wb_clk);
      #1;
      pps_i = 1'b1;
      repeat (4) @(posedge wb_clk);
      #1;
      pps_i = 1'b0;
      repeat (4) @(posedge wb_clk);   // synchronized edge lands three cycles after the rise
   endtask

   task automatic report_test(input string name);
      tests++;
      if (errors == mark)
         $display("test %s passed", name);
      else
         $display("test %s failed with %0d errors", name, errors - mark);
      mark = errors;
   endtask

   //////////////////////////////
   // stimulus
   initial
   begin
      wb_rst    = 1'b1;
      wb_cyc_i  = 1'b0;
      wb_stb_i  = 1'b0;
      wb_we_i   = 1'b0;
      wb_adr_i  = '0;
      wb_dat_i  = '0;
      pps_i     = 1'b0;
      st_status = 1'b0;
      st_ld     = 1'b0;
      st_refmon = 1'b0;
      mark      = 0;
      repeat (2) @(posedge wb_clk);
      #1;
      wb_rst = 1'b0;
      @(negedge wb_clk);

      expect_eq("cgen outputs after reset", {14'd0, cgen_sync_b, cgen_ref_sel}, 16'h0003);
      host_access(1'b1, misc_adr(MISC_CGEN_CTRL), 16'h0002, rd);
      @(negedge wb_clk);
      expect_eq("cgen outputs after write", {14'd0, cgen_sync_b, cgen_ref_sel}, 16'h0002);
      host_access(1'b0, misc_adr(MISC_CGEN_CTRL), 16'h0, rd);
      expect_eq("cgen control readback", rd, 16'h0002);
      host_access(1'b1, misc_adr(MISC_CGEN_CTRL), 16'h0001, rd);
      @(negedge wb_clk);
      expect_eq("cgen outputs after write", {14'd0, cgen_sync_b, cgen_ref_sel}, 16'h0001);
      for (int i = 0; i < 4; i++)
      begin
         rnd = $random(seed);
         host_access(1'b1, misc_adr(MISC_TEST), rnd[15:0], rd);
         host_access(1'b0, misc_adr(MISC_TEST), 16'h0, rd);
         expect_eq("scratch readback", rd, rnd[15:0]);
      end
      @(posedge wb_clk);
      #1;
      st_status = 1'b1;   // bits 2:0 are status, lock, refmon
      st_refmon = 1'b1;
      host_access(1'b0, misc_adr(MISC_CGEN_ST), 16'h0, rd);
      expect_eq("cgen status", rd, 16'h0005);
      @(posedge wb_clk);
      #1;
      st_status = 1'b0;
      st_ld     = 1'b1;   // refmon stays set
      host_access(1'b0, misc_adr(MISC_CGEN_ST), 16'h0, rd);
      expect_eq("cgen status", rd, 16'h0003);
      host_access(1'b0, misc_adr(7'd10), 16'h0, rd);
      expect_eq("unused misc address", rd, 16'hbeef);
      report_test("misc registers");

      host_access(1'b0, rb_adr(RB_COMPAT, 1'b0), 16'h0, rd);
      expect_eq("compat minor", rd, 16'h0000);
      host_access(1'b0, rb_adr(RB_COMPAT, 1'b1), 16'h0, rd);
      expect_eq("compat major", rd, 16'h0009);
      rnd = $random(seed);
      put_setting(SR_REG_TEST32, rnd);
      host_access(1'b0, rb_adr(RB_TEST32, 1'b0), 16'h0, rd);
      expect_eq("test register low half", rd, rnd[15:0]);
      host_access(1'b0, rb_adr(RB_TEST32, 1'b1), 16'h0, rd);
      expect_eq("test register high half", rd, rnd[31:16]);
      report_test("readback and settings pairing");

      secs_set = $random(seed);
      put_setting(SR_TIME64, secs_set);
      put_setting(SR_TIME64 + 8'd1, 32'd990);
      put_setting(SR_TIME64 + 8'd2, 32'd1);   // load now
      repeat (20) @(posedge wb_clk);
      read_time(rb_adr(RB_TIME_HI, 1'b0), t_now);
      secs_set = secs_set + 32'd1;   // one rollover ten ticks after the load
      expect_eq("seconds low after rollover", t_now[47:32], secs_set[15:0]);
      expect_eq("seconds high after rollover", t_now[63:48], secs_set[31:16]);
      expect_true("ticks below ticks per second", t_now[31:0] < TICKS);
      report_test("immediate time load");

      secs_pps = secs_set + 32'd100;
      put_setting(SR_TIME64, secs_pps);
      put_setting(SR_TIME64 + 8'd1, 32'd0);
      put_setting(SR_TIME64 + 8'd2, 32'd0);   // wait for pps
      repeat (20) @(posedge wb_clk);
      read_time(rb_adr(RB_TIME_HI, 1'b0), t_now);
      expect_true("seconds stay put without pps", t_now[63:32] != secs_pps);
      pulse_pps();
      read_time(rb_adr(RB_TIME_HI, 1'b0), t_now);
      expect_eq("seconds low after pps", t_now[47:32], secs_pps[15:0]);
      expect_eq("seconds high after pps", t_now[63:48], secs_pps[31:16]);
      report_test("pps armed load");

      read_time(rb_adr(RB_TIME_HI, 1'b0), t_now);
      pulse_pps();
      read_time(rb_adr(RB_TIME_HI, 1'b0), t_after);
      read_time(rb_adr(RB_PPS_HI, 1'b0), t_pps);
      expect_true("pps time not before earlier read", t_pps >= t_now);
      expect_true("pps time not after later read", t_pps <= t_after);
      report_test("pps latch");

      $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
      if (errors == 0)
         $display("** PASS **");
      else
         $display("** FAIL **");
      $finish;
   end

   // watchdog
   initial
   begin
      cycles = 0;
      while (cycles < MAX_CYCLES)
      begin
         @(posedge wb_clk);
         cycles++;
      end
      $display("timeout, run stopped after %0d cycles", cycles);
      $display("** FAIL **");
      $finish;
   end

endmodule

`default_nettype wire

// File: sources.f
hw/wb_pkg.sv
hw/regmap_pkg.sv
hw/wb_slave_if.sv
hw/wb_intercon.sv
hw/misc_regs.sv
hw/settings_bus_16le.sv
hw/vita_timer.sv
hw/readback_mux_16le.sv
hw/ctrl_core.sv
test/ctrl_core_props.sv
test/tb_ctrl_core.sv

// File: run_sim.sh
#!/bin/sh
# builds the control plane testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

verilator --binary --assert --timescale 1ns/1ps --top-module tb_ctrl_core \
    -f sources.f --Mdir obj_dir -o tb_ctrl_core
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/tb_ctrl_core > sim.log 2>&1
run_status=$?
cat sim.log
if [ $run_status -ne 0 ]; then
    echo "simulation exited with status $run_status"
    exit 1
fi

if grep -qxF '** PASS **' sim.log; then
    echo "simulation passed"
    exit 0
fi

echo "simulation failed"
exit 1
